// File: Makefile
TOP   = tb_mips_core
BUILD = build

.PHONY: all lint clean

all:
	verilator --binary --assert -f tb.f --top-module $(TOP) -Mdir $(BUILD) -o $(TOP)
	@out="$$(./$(BUILD)/$(TOP))"; echo "$$out"; echo "$$out" | grep -q "Result: PASSED"

lint:
	verilator --lint-only --assert +incdir+hdl --top-module mips_core \
		hdl/mips_pkg.sv hdl/fetch_ctrl.sv hdl/pc_counter.sv hdl/register_file.sv \
		hdl/decode_stage.sv hdl/execute_stage.sv hdl/mips_core.sv

clean:
	rm -rf $(BUILD)

// File: hdl/decode_stage.sv
`timescale 1ns/1ns
`include "mips_defs.svh"

module decode_stage (
    input  logic                  pif,
    input  logic                  rst,
    input  logic                  fetch_valid,
    input  logic [`MIPS_XLEN-1:0] fetch_instr,
    input  logic [`MIPS_XLEN-1:0] fetch_pc,
    input  logic                  wr_en,
    input  logic [4:0]            wr_reg,
    input  logic [`MIPS_XLEN-1:0] wr_data,
    input  logic                  hilo_en,
    input  logic [`MIPS_XLEN-1:0] hi_data,
    input  logic [`MIPS_XLEN-1:0] lo_data,
    output logic                  jump_valid,
    output logic [`MIPS_XLEN-1:0] jump_target,
    output logic                  ex_valid,
    output mips_pkg::alu_op_e     ex_op,
    output logic [`MIPS_XLEN-1:0] ex_a,
    output logic [`MIPS_XLEN-1:0] ex_b,
    output logic [4:0]            ex_dest,
    output logic                  ex_writes_reg,
    output logic [`MIPS_XLEN-1:0] ex_pc
);
    logic                  d_valid;
    logic [`MIPS_XLEN-1:0] d_instr;
    logic [`MIPS_XLEN-1:0] d_pc;
    mips_pkg::opcode_e     opcode;
    mips_pkg::funct_e      funct;
    logic [4:0]            rs;
    logic [4:0]            rt;
    logic [4:0]            rd;
    logic [`MIPS_XLEN-1:0] imm_sext;
    logic [`MIPS_XLEN-1:0] imm_zext;
    logic [`MIPS_XLEN-1:0] rs_data;
    logic [`MIPS_XLEN-1:0] rt_data;
    logic [`MIPS_XLEN-1:0] rs_val;
    logic [`MIPS_XLEN-1:0] rt_val;
    logic [`MIPS_XLEN-1:0] hi_reg;
    logic [`MIPS_XLEN-1:0] lo_reg;
    logic [`MIPS_XLEN-1:0] hi_val;
    logic [`MIPS_XLEN-1:0] lo_val;
    logic [`MIPS_XLEN-1:0] pc_plus4;

    always_ff @(posedge pif) begin
        if (rst)
            d_valid <= 1'b0;
        else
            d_valid <= fetch_valid;
    end

    always_ff @(posedge pif) begin
        if (fetch_valid) begin
            d_instr <= fetch_instr;
            d_pc    <= fetch_pc;
        end
    end

    assign opcode   = mips_pkg::opcode_e'(d_instr[31:26]);
    assign funct    = mips_pkg::funct_e'(d_instr[5:0]);
    assign rs       = d_instr[25:21];
    assign rt       = d_instr[20:16];
    assign rd       = d_instr[15:11];
    assign imm_sext = {{(`MIPS_XLEN-16){d_instr[15]}}, d_instr[15:0]};
    assign imm_zext = {{(`MIPS_XLEN-16){1'b0}}, d_instr[15:0]};

    register_file rf_i (
        .pif     (pif),
        .rst     (rst),
        .raddr_a (rs),
        .raddr_b (rt),
        .rdata_a (rs_data),
        .rdata_b (rt_data),
        .we      (wr_en),
        .waddr   (wr_reg),
        .wdata   (wr_data)
    );

    // bypass the result retiring this cycle but never into r0
    assign rs_val = (wr_en && wr_reg != 5'd0 && wr_reg == rs) ? wr_data : rs_data;
    assign rt_val = (wr_en && wr_reg != 5'd0 && wr_reg == rt) ? wr_data : rt_data;

    always_ff @(posedge pif) begin
        if (rst) begin
            hi_reg <= '0;
            lo_reg <= '0;
        end else if (hilo_en) begin
            hi_reg <= hi_data;
            lo_reg <= lo_data;
        end
    end

    assign hi_val = hilo_en ? hi_data : hi_reg;
    assign lo_val = hilo_en ? lo_data : lo_reg;

    always_comb begin
        ex_op         = mips_pkg::alu_add;
        ex_a          = rs_val;
        ex_b          = rt_val;
        ex_dest       = 5'd0;
        ex_writes_reg = 1'b0;
        case (opcode)
            mips_pkg::op_special: begin
                ex_dest       = rd;
                ex_writes_reg = 1'b1;
                case (funct)
                    mips_pkg::fn_addu: ex_op = mips_pkg::alu_add;
                    mips_pkg::fn_subu: ex_op = mips_pkg::alu_sub;
                    mips_pkg::fn_and:  ex_op = mips_pkg::alu_and;
                    mips_pkg::fn_or:   ex_op = mips_pkg::alu_or;
                    mips_pkg::fn_slt:  ex_op = mips_pkg::alu_slt;
                    mips_pkg::fn_multu: begin
                        ex_op         = mips_pkg::alu_mul;
                        ex_dest       = 5'd0;
                        ex_writes_reg = 1'b0;
                    end
                    mips_pkg::fn_mfhi: begin
                        ex_op = mips_pkg::alu_hi;
                        ex_a  = hi_val;
                    end
                    mips_pkg::fn_mflo: begin
                        ex_op = mips_pkg::alu_lo;
                        ex_a  = lo_val;
                    end
                    default: begin
                        ex_dest       = 5'd0;
                        ex_writes_reg = 1'b0;
                    end
                endcase
            end
            mips_pkg::op_addiu: begin
                ex_b          = imm_sext;
                ex_dest       = rt;
                ex_writes_reg = 1'b1;
            end
            mips_pkg::op_ori: begin
                ex_op         = mips_pkg::alu_or;
                ex_b          = imm_zext;
                ex_dest       = rt;
                ex_writes_reg = 1'b1;
            end
            mips_pkg::op_lui: begin
                ex_op         = mips_pkg::alu_lui;
                ex_b          = imm_zext;
                ex_dest       = rt;
                ex_writes_reg = 1'b1;
            end
            // J retires as a no-op
            default: ex_writes_reg = 1'b0;
        endcase
    end

    assign ex_valid = d_valid;
    assign ex_pc    = d_pc;

    assign pc_plus4    = d_pc + `MIPS_XLEN'(4);
    assign jump_valid  = d_valid && (opcode == mips_pkg::op_j);
    assign jump_target = {pc_plus4[`MIPS_XLEN-1 -: 4], d_instr[25:0], 2'b00};

    // a jump request comes only from a J taken in by a valid fetch
    a_jump_is_j: assert property (@(posedge pif) disable iff (rst)
        jump_valid |-> $past(fetch_valid) && $past(fetch_instr[31:26]) == mips_pkg::op_j);

endmodule

// File: hdl/execute_stage.sv
`timescale 1ns/1ns
`include "mips_defs.svh"

module execute_stage (
    input  logic                  pif,
    input  logic                  rst,
    input  logic                  ex_valid,
    input  mips_pkg::alu_op_e     ex_op,
    input  logic [`MIPS_XLEN-1:0] ex_a,
    input  logic [`MIPS_XLEN-1:0] ex_b,
    input  logic [4:0]            ex_dest,
    input  logic                  ex_writes_reg,
    input  logic [`MIPS_XLEN-1:0] ex_pc,
    output logic                  wr_en,
    output logic [4:0]            wr_reg,
    output logic [`MIPS_XLEN-1:0] wr_data,
    output logic                  hilo_en,
    output logic [`MIPS_XLEN-1:0] hi_data,
    output logic [`MIPS_XLEN-1:0] lo_data,
    output logic                  ret_valid,
    output logic [`MIPS_XLEN-1:0] ret_pc
);
    localparam int PW = 2 * `MIPS_XLEN;

    logic                  x_valid;
    mips_pkg::alu_op_e     x_op;
    logic [`MIPS_XLEN-1:0] x_a;
    logic [`MIPS_XLEN-1:0] x_b;
    logic [4:0]            x_dest;
    logic                  x_writes;
    logic [`MIPS_XLEN-1:0] x_pc;
    logic [PW-1:0]         product;
    logic [`MIPS_XLEN-1:0] result;

    always_ff @(posedge pif) begin
        if (rst)
            x_valid <= 1'b0;
        else
            x_valid <= ex_valid;
    end

    always_ff @(posedge pif) begin
        if (ex_valid) begin
            x_op     <= ex_op;
            x_a      <= ex_a;
            x_b      <= ex_b;
            x_dest   <= ex_dest;
            x_writes <= ex_writes_reg;
            x_pc     <= ex_pc;
        end
    end

    // unsigned full-width product for multu
    assign product = PW'(x_a) * PW'(x_b);

    always_comb begin
        case (x_op)
            mips_pkg::alu_add: result = x_a + x_b;
            mips_pkg::alu_sub: result = x_a - x_b;
            mips_pkg::alu_and: result = x_a & x_b;
            mips_pkg::alu_or:  result = x_a | x_b;
            mips_pkg::alu_slt: result = `MIPS_XLEN'($signed(x_a) < $signed(x_b));
            mips_pkg::alu_lui: result = {x_b[15:0], 16'h0000};
            mips_pkg::alu_mul: result = product[`MIPS_XLEN-1:0];
            mips_pkg::alu_hi,
            mips_pkg::alu_lo:  result = x_a;
            default:           result = '0;
        endcase
    end

    assign wr_en   = x_valid && x_writes;
    assign wr_reg  = x_dest;
    assign wr_data = result;

    assign hilo_en = x_valid && (x_op == mips_pkg::alu_mul);
    assign hi_data = product[PW-1:`MIPS_XLEN];
    assign lo_data = product[`MIPS_XLEN-1:0];

    assign ret_valid = x_valid;
    assign ret_pc    = x_pc;

endmodule

// File: hdl/fetch_ctrl.sv
`timescale 1ns/1ns
`include "mips_defs.svh"

module fetch_ctrl (
    input  logic                  pif,
    input  logic                  rst,
    input  logic                  start,
    input  logic [`MIPS_XLEN-1:0] pc,
    input  logic                  wb_ack,
    input  logic [`MIPS_XLEN-1:0] wb_rdat,
    output logic                  wb_cyc,
    output logic                  wb_stb,
    output logic                  fetch_valid,
    output logic [`MIPS_XLEN-1:0] fetch_instr,
    output logic                  pc_step,
    output logic                  done
);
    localparam int DRAIN_W = $clog2(`MIPS_DRAIN_CYCLES + 1);

    mips_pkg::fetch_state_e state;
    mips_pkg::fetch_state_e state_next;
    logic [DRAIN_W-1:0]     drain_cnt;
    logic                   acked;
    logic                   is_break;

    assign acked = wb_stb && wb_ack;
    // only opcode and funct matter, the code field is ignored
    assign is_break = (wb_rdat[31:26] == mips_pkg::op_special) &&
                      (wb_rdat[5:0] == mips_pkg::fn_break);

    always_comb begin
        state_next = state;
        case (state)
            mips_pkg::st_idle, mips_pkg::st_done: begin
                if (start)
                    state_next = mips_pkg::st_run;
            end
            mips_pkg::st_run: begin
                if (acked && is_break)
                    state_next = mips_pkg::st_drain;
            end
            mips_pkg::st_drain: begin
                if (drain_cnt == DRAIN_W'(`MIPS_DRAIN_CYCLES - 1))
                    state_next = mips_pkg::st_done;
            end
            default: state_next = mips_pkg::st_idle;
        endcase
    end

    always_ff @(posedge pif) begin
        if (rst) begin
            state     <= mips_pkg::st_idle;
            drain_cnt <= '0;
            wb_cyc    <= 1'b0;
            wb_stb    <= 1'b0;
        end else begin
            state  <= state_next;
            wb_cyc <= (state_next == mips_pkg::st_run);
            wb_stb <= (state_next == mips_pkg::st_run);
            if (state == mips_pkg::st_drain)
                drain_cnt <= drain_cnt + 1'b1;
            else
                drain_cnt <= '0;
        end
    end

    // BREAK is swallowed here and never reaches decode
    assign fetch_valid = acked && !is_break;
    assign fetch_instr = wb_rdat;
    assign pc_step     = fetch_valid;
    assign done        = (state == mips_pkg::st_done);

    a_stb_in_cyc: assert property (@(posedge pif) disable iff (rst) wb_stb |-> wb_cyc);

    // wishbone address must hold until the slave acks
    a_adr_hold: assert property (@(posedge pif) disable iff (rst)
        wb_stb && !wb_ack |=> $stable(pc));

endmodule

// File: hdl/mips_core.sv
`timescale 1ns/1ns
`include "mips_defs.svh"

module mips_core (
    input  logic                  pif,
    input  logic                  rst,
    input  logic                  start,
    output logic                  wb_cyc,
    output logic                  wb_stb,
    output logic [`MIPS_XLEN-1:0] wb_adr,
    input  logic [`MIPS_XLEN-1:0] wb_rdat,
    input  logic                  wb_ack,
    output logic                  done,
    output logic                  ret_valid,
    output logic [`MIPS_XLEN-1:0] ret_pc,
    output logic                  ret_wr_en,
    output logic [4:0]            ret_reg,
    output logic [`MIPS_XLEN-1:0] ret_data,
    output logic                  ret_hilo_en,
    output logic [`MIPS_XLEN-1:0] ret_hi,
    output logic [`MIPS_XLEN-1:0] ret_lo
);
    logic                  fetch_valid;
    logic [`MIPS_XLEN-1:0] fetch_instr;
    logic [`MIPS_XLEN-1:0] fetch_pc;
    logic                  pc_step;
    logic                  jump_valid;
    logic [`MIPS_XLEN-1:0] jump_target;
    logic                  ex_valid;
    mips_pkg::alu_op_e     ex_op;
    logic [`MIPS_XLEN-1:0] ex_a;
    logic [`MIPS_XLEN-1:0] ex_b;
    logic [4:0]            ex_dest;
    logic                  ex_writes_reg;
    logic [`MIPS_XLEN-1:0] ex_pc;

    fetch_ctrl fetch_i (
        .pif         (pif),
        .rst         (rst),
        .start       (start),
        .pc          (wb_adr),
        .wb_ack      (wb_ack),
        .wb_rdat     (wb_rdat),
        .wb_cyc      (wb_cyc),
        .wb_stb      (wb_stb),
        .fetch_valid (fetch_valid),
        .fetch_instr (fetch_instr),
        .pc_step     (pc_step),
        .done        (done)
    );

    // the program counter is the wishbone address
    pc_counter pc_i (
        .pif         (pif),
        .rst         (rst),
        .pc_step     (pc_step),
        .jump_valid  (jump_valid),
        .jump_target (jump_target),
        .pc          (wb_adr),
        .fetch_pc    (fetch_pc)
    );

    decode_stage decode_i (
        .pif           (pif),
        .rst           (rst),
        .fetch_valid   (fetch_valid),
        .fetch_instr   (fetch_instr),
        .fetch_pc      (fetch_pc),
        .wr_en         (ret_wr_en),
        .wr_reg        (ret_reg),
        .wr_data       (ret_data),
        .hilo_en       (ret_hilo_en),
        .hi_data       (ret_hi),
        .lo_data       (ret_lo),
        .jump_valid    (jump_valid),
        .jump_target   (jump_target),
        .ex_valid      (ex_valid),
        .ex_op         (ex_op),
        .ex_a          (ex_a),
        .ex_b          (ex_b),
        .ex_dest       (ex_dest),
        .ex_writes_reg (ex_writes_reg),
        .ex_pc         (ex_pc)
    );

    execute_stage execute_i (
        .pif           (pif),
        .rst           (rst),
        .ex_valid      (ex_valid),
        .ex_op         (ex_op),
        .ex_a          (ex_a),
        .ex_b          (ex_b),
        .ex_dest       (ex_dest),
        .ex_writes_reg (ex_writes_reg),
        .ex_pc         (ex_pc),
        .wr_en         (ret_wr_en),
        .wr_reg        (ret_reg),
        .wr_data       (ret_data),
        .hilo_en       (ret_hilo_en),
        .hi_data       (ret_hi),
        .lo_data       (ret_lo),
        .ret_valid     (ret_valid),
        .ret_pc        (ret_pc)
    );

endmodule

// File: hdl/mips_defs.svh
`ifndef MIPS_DEFS_SVH
`define MIPS_DEFS_SVH

// data path and address width
`define MIPS_XLEN 32

// first fetch address after reset
`define MIPS_RESET_PC 32'h0000_0000

// general purpose registers, r0 included
`define MIPS_NREGS 32

// cycles spent in drain between an acked BREAK and done
`define MIPS_DRAIN_CYCLES 2

`endif

// File: hdl/mips_pkg.sv
package mips_pkg;

    // primary opcode field, instr[31:26]
    typedef enum logic [5:0] {
        op_special = 6'h00,
        op_j       = 6'h02,
        op_addiu   = 6'h09,
        op_ori     = 6'h0d,
        op_lui     = 6'h0f
    } opcode_e;

    // function field of special instructions, instr[5:0]
    typedef enum logic [5:0] {
        fn_mfhi  = 6'h10,
        fn_mflo  = 6'h12,
        fn_multu = 6'h19,
        fn_addu  = 6'h21,
        fn_subu  = 6'h23,
        fn_and   = 6'h24,
        fn_or    = 6'h25,
        fn_slt   = 6'h2a,
        fn_break = 6'h0d
    } funct_e;

    typedef enum logic [3:0] {
        alu_add,
        alu_sub,
        alu_and,
        alu_or,
        alu_slt,
        alu_lui,
        alu_mul,
        alu_hi,
        alu_lo
    } alu_op_e;

    typedef enum logic [2:0] {
        st_idle,
        st_run,
        st_drain,
        st_done
    } fetch_state_e;

endpackage

// File: hdl/pc_counter.sv
`timescale 1ns/1ns
`include "mips_defs.svh"

module pc_counter (
    input  logic                  pif,
    input  logic                  rst,
    input  logic                  pc_step,
    input  logic                  jump_valid,
    input  logic [`MIPS_XLEN-1:0] jump_target,
    output logic [`MIPS_XLEN-1:0] pc,
    output logic [`MIPS_XLEN-1:0] fetch_pc
);
    logic                  pend_valid;
    logic [`MIPS_XLEN-1:0] pend_target;

    // the jump lands on the step after the delay slot's ack
    always_ff @(posedge pif) begin
        if (rst) begin
            pc         <= `MIPS_RESET_PC;
            pend_valid <= 1'b0;
        end else if (pc_step) begin
            if (jump_valid)
                pc <= jump_target;
            else if (pend_valid)
                pc <= pend_target;
            else
                pc <= pc + `MIPS_XLEN'(4);
            pend_valid <= 1'b0;
        end else if (jump_valid) begin
            pend_valid <= 1'b1;
        end
    end

    always_ff @(posedge pif) begin
        if (jump_valid)
            pend_target <= jump_target;
    end

    assign fetch_pc = pc;

    a_pc_aligned: assert property (@(posedge pif) disable iff (rst) pc[1:0] == 2'b00);

endmodule

// File: hdl/register_file.sv
`timescale 1ns/1ns
`include "mips_defs.svh"

module register_file (
    input  logic                  pif,
    input  logic                  rst,
    input  logic [4:0]            raddr_a,
    input  logic [4:0]            raddr_b,
    output logic [`MIPS_XLEN-1:0] rdata_a,
    output logic [`MIPS_XLEN-1:0] rdata_b,
    input  logic                  we,
    input  logic [4:0]            waddr,
    input  logic [`MIPS_XLEN-1:0] wdata
);
    logic [`MIPS_XLEN-1:0] regs [`MIPS_NREGS];

    always_ff @(posedge pif) begin
        if (rst) begin
            for (int i = 0; i < `MIPS_NREGS; i++) begin
                regs[i] <= '0;
            end
        end else if (we && waddr != 5'd0) begin
            regs[waddr] <= wdata;
        end
    end

    // r0 is hardwired, whatever the array holds
    assign rdata_a = (raddr_a == 5'd0) ? '0 : regs[raddr_a];
    assign rdata_b = (raddr_b == 5'd0) ? '0 : regs[raddr_b];

    a_waddr_known: assert property (@(posedge pif) disable iff (rst)
        we |-> !$isunknown(waddr));

endmodule

// File: tb.f
+incdir+hdl
hdl/mips_pkg.sv
hdl/fetch_ctrl.sv
hdl/pc_counter.sv
hdl/register_file.sv
hdl/decode_stage.sv
hdl/execute_stage.sv
hdl/mips_core.sv
tb/tb_mips_core.sv

// File: tb/tb_mips_core.sv
`timescale 1ns/1ns
`include "mips_defs.svh"

module tb_mips_core;

    localparam int mem_words   = 64;
    localparam int ret_timeout = 40;

    localparam logic [2:0] grp_arith = 3'd1;
    localparam logic [2:0] grp_fwd   = 3'd2;
    localparam logic [2:0] grp_mul   = 3'd3;
    localparam logic [2:0] grp_jump  = 3'd4;

    // one expected retire, in program order
    typedef struct packed {
        logic [31:0] pc;
        logic        wr;
        logic [4:0]  rd;
        logic [31:0] data;
        logic        hilo;
        logic [31:0] hi;
        logic [31:0] lo;
        logic [2:0]  grp;
    } retire_t;

    logic        pif;
    logic        rst;
    logic        start;
    logic        wb_cyc;
    logic        wb_stb;
    logic [31:0] wb_adr;
    logic [31:0] wb_rdat;
    logic        wb_ack;
    logic        done;
    logic        ret_valid;
    logic [31:0] ret_pc;
    logic        ret_wr_en;
    logic [4:0]  ret_reg;
    logic [31:0] ret_data;
    logic        ret_hilo_en;
    logic [31:0] ret_hi;
    logic [31:0] ret_lo;

    logic [31:0] mem [mem_words];
    retire_t     exp_q[$];
    logic [31:0] next_addr;
    logic [31:0] lfsr = 32'h10cf;
    int          cycle_cnt = 0;
    int          retire_cnt = 0;
    int          brk_ack_cycle = 0;
    bit          brk_seen = 1'b0;
    int          errors = 0;
    int          tests_run = 0;
    int          tests_failed = 0;

    mips_core dut_i (
        .pif         (pif),
        .rst         (rst),
        .start       (start),
        .wb_cyc      (wb_cyc),
        .wb_stb      (wb_stb),
        .wb_adr      (wb_adr),
        .wb_rdat     (wb_rdat),
        .wb_ack      (wb_ack),
        .done        (done),
        .ret_valid   (ret_valid),
        .ret_pc      (ret_pc),
        .ret_wr_en   (ret_wr_en),
        .ret_reg     (ret_reg),
        .ret_data    (ret_data),
        .ret_hilo_en (ret_hilo_en),
        .ret_hi      (ret_hi),
        .ret_lo      (ret_lo)
    );

    initial begin
        pif = 1'b0;
        forever #4 pif = ~pif;
    end

    always @(posedge pif) cycle_cnt <= cycle_cnt + 1;

    always @(negedge pif) begin
        if (!rst && ret_valid)
            retire_cnt <= retire_cnt + 1;
    end

    function automatic logic [31:0] r_type(logic [4:0] rs, logic [4:0] rt, logic [4:0] rd,
                                           logic [5:0] fn);
        return {mips_pkg::op_special, rs, rt, rd, 5'd0, fn};
    endfunction

    function automatic logic [31:0] i_type(logic [5:0] op, logic [4:0] rs, logic [4:0] rt,
                                           logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    function automatic logic [31:0] j_type(logic [31:0] target);
        return {mips_pkg::op_j, target[27:2]};
    endfunction

    // taps 32, 22, 2, 1
    function automatic logic [31:0] lfsr_next(logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic draw_waits(output int waits);
        logic [1:0] bits;
        for (int i = 0; i < 2; i++) begin
            lfsr    = lfsr_next(lfsr);
            bits[i] = lfsr[0];
        end
        waits = (bits == 2'd3) ? 0 : int'(bits);
    endtask

    function automatic string group_name(logic [2:0] g);
        case (g)
            grp_arith: return "arithmetic";
            grp_fwd:   return "forwarding";
            grp_mul:   return "multu";
            grp_jump:  return "jump";
            default:   return "unknown";
        endcase
    endfunction

    task automatic check_bit(string name, logic got, logic exp);
        assert (got === exp) else begin
            $display("[FAIL] %0t ns: %s expected %b, got %b", $time, name, exp, got);
            errors++;
        end
    endtask

    task automatic check_word(string name, logic [31:0] got, logic [31:0] exp);
        assert (got === exp) else begin
            $display("[FAIL] %0t ns: %s expected %h, got %h", $time, name, exp, got);
            errors++;
        end
    endtask

    task automatic report_test(string name, int errs_before);
        tests_run++;
        if (errors == errs_before) begin
            $display("test %-11s ok", name);
        end else begin
            tests_failed++;
            $display("test %-11s %0d error(s)", name, errors - errs_before);
        end
    endtask

    task automatic end_run();
        $display("tests: %0d run, %0d failed, %0d retired, %0d errors",
                 tests_run, tests_failed, retire_cnt, errors);
        if (errors == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    endtask

    task automatic report_timeout(string why);
        $display("timeout at %0t ns: %s", $time, why);
        errors++;
    endtask

    task automatic wait_retire(output bit got);
        int n;
        got = 1'b0;
        n   = 0;
        while (!got && n < ret_timeout) begin
            @(negedge pif);
            n++;
            got = ret_valid;
        end
    endtask

    task automatic wait_done(output bit got);
        int n;
        got = 1'b0;
        n   = 0;
        while (!got && n < ret_timeout) begin
            @(negedge pif);
            n++;
            got = done;
        end
    endtask

    task automatic place_word(logic [31:0] word);
        mem[next_addr[7:2]] = word;
        next_addr           = next_addr + 32'd4;
    endtask

    task automatic add_row(logic [31:0] word, logic wr, logic [4:0] rd, logic [31:0] data,
                           logic hilo, logic [31:0] hi, logic [31:0] lo, logic [2:0] grp);
        retire_t r;
        r.pc   = next_addr;
        r.wr   = wr;
        r.rd   = rd;
        r.data = data;
        r.hilo = hilo;
        r.hi   = hi;
        r.lo   = lo;
        r.grp  = grp;
        exp_q.push_back(r);
        place_word(word);
    endtask

    task automatic write_row(logic [31:0] word, logic [4:0] rd, logic [31:0] data,
                             logic [2:0] grp);
        add_row(word, 1'b1, rd, data, 1'b0, '0, '0, grp);
    endtask

    task automatic hilo_row(logic [31:0] word, logic [31:0] hi, logic [31:0] lo,
                            logic [2:0] grp);
        add_row(word, 1'b0, 5'd0, '0, 1'b1, hi, lo, grp);
    endtask

    task automatic plain_row(logic [31:0] word, logic [2:0] grp);
        add_row(word, 1'b0, 5'd0, '0, 1'b0, '0, '0, grp);
    endtask

    task automatic load_program();
        for (int i = 0; i < mem_words; i++)
            mem[i] = 32'hfc00_0000 | (32'(i) << 2);
        next_addr = `MIPS_RESET_PC;
        write_row(i_type(mips_pkg::op_addiu, 5'd0, 5'd1, 16'd5), 5'd1, 32'h0000_0005, grp_arith);
        write_row(i_type(mips_pkg::op_addiu, 5'd0, 5'd2, 16'hfffd), 5'd2, 32'hffff_fffd,
                  grp_arith);
        write_row(i_type(mips_pkg::op_ori, 5'd0, 5'd3, 16'h8001), 5'd3, 32'h0000_8001, grp_arith);
        write_row(i_type(mips_pkg::op_lui, 5'd0, 5'd4, 16'h8000), 5'd4, 32'h8000_0000, grp_arith);
        write_row(r_type(5'd1, 5'd2, 5'd5, mips_pkg::fn_addu), 5'd5, 32'h0000_0002, grp_arith);
        write_row(r_type(5'd2, 5'd1, 5'd6, mips_pkg::fn_subu), 5'd6, 32'hffff_fff8, grp_arith);
        write_row(r_type(5'd6, 5'd3, 5'd7, mips_pkg::fn_and), 5'd7, 32'h0000_8000, grp_arith);
        write_row(r_type(5'd4, 5'd1, 5'd8, mips_pkg::fn_or), 5'd8, 32'h8000_0005, grp_arith);
        write_row(r_type(5'd4, 5'd2, 5'd9, mips_pkg::fn_slt), 5'd9, 32'h0000_0001, grp_arith);
        write_row(r_type(5'd2, 5'd6, 5'd10, mips_pkg::fn_slt), 5'd10, 32'h0000_0000, grp_arith);
        // r0 takes the write on the trace, but reads back zero
        write_row(i_type(mips_pkg::op_addiu, 5'd1, 5'd0, 16'd7), 5'd0, 32'h0000_000c, grp_arith);
        write_row(r_type(5'd0, 5'd1, 5'd11, mips_pkg::fn_addu), 5'd11, 32'h0000_0005, grp_arith);
        write_row(i_type(mips_pkg::op_addiu, 5'd1, 5'd12, 16'd1), 5'd12, 32'h0000_0006, grp_fwd);
        write_row(r_type(5'd12, 5'd12, 5'd13, mips_pkg::fn_addu), 5'd13, 32'h0000_000c, grp_fwd);
        write_row(r_type(5'd13, 5'd12, 5'd14, mips_pkg::fn_addu), 5'd14, 32'h0000_0012, grp_fwd);
        write_row(r_type(5'd14, 5'd13, 5'd15, mips_pkg::fn_addu), 5'd15, 32'h0000_001e, grp_fwd);
        write_row(i_type(mips_pkg::op_lui, 5'd0, 5'd16, 16'hffff), 5'd16, 32'hffff_0000, grp_mul);
        write_row(i_type(mips_pkg::op_ori, 5'd16, 5'd16, 16'hfff0), 5'd16, 32'hffff_fff0, grp_mul);
        write_row(i_type(mips_pkg::op_lui, 5'd0, 5'd17, 16'h8000), 5'd17, 32'h8000_0000, grp_mul);
        write_row(i_type(mips_pkg::op_ori, 5'd17, 5'd17, 16'h0003), 5'd17, 32'h8000_0003, grp_mul);
        // (2^32 - 16) * (2^31 + 3) = 2^63 - 5 * 2^32 - 48
        hilo_row(r_type(5'd16, 5'd17, 5'd0, mips_pkg::fn_multu), 32'h7fff_fffa, 32'hffff_ffd0,
                 grp_mul);
        write_row(r_type(5'd0, 5'd0, 5'd18, mips_pkg::fn_mfhi), 5'd18, 32'h7fff_fffa, grp_mul);
        write_row(r_type(5'd0, 5'd0, 5'd19, mips_pkg::fn_mflo), 5'd19, 32'hffff_ffd0, grp_mul);
        plain_row(j_type(32'h0000_0080), grp_jump);
        write_row(i_type(mips_pkg::op_addiu, 5'd0, 5'd20, 16'h0011), 5'd20, 32'h0000_0011,
                  grp_jump);
        while (next_addr < 32'h0000_0080)
            place_word(i_type(mips_pkg::op_addiu, 5'd0, 5'd20, 16'h0bad));
        write_row(r_type(5'd20, 5'd15, 5'd21, mips_pkg::fn_addu), 5'd21, 32'h0000_002f, grp_jump);
        place_word(r_type(5'd0, 5'd0, 5'd0, mips_pkg::fn_break));
    endtask

    // wishbone slave with 0 to 2 wait states per read
    initial begin : wishbone_slave
        int waits_left;
        bit busy;
        wb_ack     = 1'b0;
        wb_rdat    = '0;
        waits_left = 0;
        busy       = 1'b0;
        forever begin
            @(posedge pif);
            #1;
            if (wb_ack) begin
                wb_ack = 1'b0;
                busy   = 1'b0;
            end
            if (wb_stb === 1'b1 && !busy) begin
                busy = 1'b1;
                draw_waits(waits_left);
            end
            if (busy && waits_left > 0) begin
                waits_left--;
            end else if (busy) begin
                if (wb_adr[31:2] >= 30'(mem_words)) begin
                    $display("error at %0t ns: fetch from %h is outside the memory", $time, wb_adr);
                    errors++;
                    wb_rdat = '0;
                end else begin
                    wb_rdat = mem[wb_adr[7:2]];
                end
                wb_ack = 1'b1;
                if (wb_rdat[31:26] == mips_pkg::op_special &&
                    wb_rdat[5:0] == mips_pkg::fn_break) begin
                    brk_ack_cycle = cycle_cnt;
                    brk_seen      = 1'b1;
                end
            end
        end
    end

    initial begin : main_sequence
        bit         got;
        bit         timed_out;
        retire_t    r;
        int         mark;
        logic [2:0] grp;
        rst       = 1'b1;
        start     = 1'b0;
        timed_out = 1'b0;
        load_program();
        repeat (8) @(posedge pif);
        #1;
        rst = 1'b0;

        mark = errors;
        repeat (6) begin
            @(negedge pif);
            check_bit("wb_cyc", wb_cyc, 1'b0);
            check_bit("wb_stb", wb_stb, 1'b0);
            check_bit("done", done, 1'b0);
            check_bit("ret_valid", ret_valid, 1'b0);
            check_word("wb_adr", wb_adr, `MIPS_RESET_PC);
        end
        report_test("reset", mark);

        @(posedge pif);
        #1;
        start = 1'b1;
        @(posedge pif);
        #1;
        start = 1'b0;

        mark = errors;
        grp  = exp_q[0].grp;
        foreach (exp_q[i]) begin
            r = exp_q[i];
            if (r.grp != grp) begin
                report_test(group_name(grp), mark);
                grp  = r.grp;
                mark = errors;
            end
            wait_retire(got);
            if (!got) begin
                report_timeout($sformatf("no retire for pc %h", r.pc));
                timed_out = 1'b1;
                break;
            end
            check_word("ret_pc", ret_pc, r.pc);
            check_bit("ret_wr_en", ret_wr_en, r.wr);
            if (r.wr) begin
                check_word("ret_reg", 32'(ret_reg), 32'(r.rd));
                check_word("ret_data", ret_data, r.data);
            end
            check_bit("ret_hilo_en", ret_hilo_en, r.hilo);
            if (r.hilo) begin
                check_word("ret_hi", ret_hi, r.hi);
                check_word("ret_lo", ret_lo, r.lo);
            end
        end
        report_test(group_name(grp), mark);

        if (!timed_out) begin
            mark = errors;
            wait_done(got);
            if (!got) begin
                report_timeout("done never rose after the BREAK");
            end else begin
                assert (brk_seen) else begin
                    $display("error at %0t ns: done rose but no BREAK was ever acked", $time);
                    errors++;
                end
                check_word("done delay", 32'(cycle_cnt - brk_ack_cycle),
                           32'(`MIPS_DRAIN_CYCLES + 1));
                check_bit("wb_cyc", wb_cyc, 1'b0);
                check_bit("wb_stb", wb_stb, 1'b0);
                // nothing may retire once the pipeline has drained
                repeat (4) @(negedge pif);
                check_bit("done", done, 1'b1);
                check_word("retire count", 32'(retire_cnt), 32'(exp_q.size()));
            end
            report_test("break", mark);
        end
        end_run();
    end

endmodule
